// ==== src/cpuPkg.sv ====
// CPU package with opcode map, datapath widths, stack and vector addresses
package cpuPkg;

  // Field widths
  localparam int OPC_W  = 4;                     // Opcode field
  localparam int ADDR_W = 16;                    // Program and stack address

  // Opcode map of the decoder
  localparam logic [OPC_W-1:0] OPC_NOP   = 4'b0000;
  localparam logic [OPC_W-1:0] OPC_SETC  = 4'b0001; // CLRC and SETC
  localparam logic [OPC_W-1:0] OPC_ALU   = 4'b0010; // NOT INC DEC MOV ADD SUB AND OR
  localparam logic [OPC_W-1:0] OPC_OUT   = 4'b0011;
  localparam logic [OPC_W-1:0] OPC_IN    = 4'b0100;
  localparam logic [OPC_W-1:0] OPC_SHIFT = 4'b0101; // SHL SHR and LDM
  localparam logic [OPC_W-1:0] OPC_PUSH  = 4'b0110;
  localparam logic [OPC_W-1:0] OPC_POP   = 4'b0111;
  localparam logic [OPC_W-1:0] OPC_JMP   = 4'b1000; // JMP JN JC JZ
  localparam logic [OPC_W-1:0] OPC_CALL  = 4'b1001;
  localparam logic [OPC_W-1:0] OPC_RET   = 4'b1010;
  localparam logic [OPC_W-1:0] OPC_LDD   = 4'b1011;
  localparam logic [OPC_W-1:0] OPC_STD   = 4'b1100;
  localparam logic [OPC_W-1:0] OPC_RETI  = 4'b1110; // 1101 and 1111 unused

  // Memory map constants
  localparam logic [ADDR_W-1:0] STACK_TOP  = 16'h0FFF; // First free stack slot
  localparam logic [ADDR_W-1:0] INT_VECTOR = 16'h0010; // Interrupt handler entry

  // Call sequencer states
  // BUBBLE covers the one dead cycle after CALL or an interrupt
  typedef enum logic [0:0] {
    IDLE   = 1'b0,                               // Normal decode
    BUBBLE = 1'b1                                // Forced NOP, stall
  } seqState;

endpackage

// ==== src/ctrlIf.sv ====
// Control bundle carrying the decoded control bits from decoder to datapath users
interface ctrlIf;

  logic aluOp;                                   // ALU operation select
  logic aluSrc;                                  // Immediate operand
  logic regWrite;                                // Register file write
  logic memRead;                                 // Data memory read
  logic memWrite;                                // Data memory write
  logic memToReg;                                // Writeback from memory
  logic branch;                                  // Jump or call
  logic outEn;                                   // Output port write
  logic inEn;                                    // Input port read
  logic pushPop;                                 // 1 push, 0 pop
  logic pushPc;                                  // Push return address
  logic popPc;                                   // Load pc from stack
  logic stackOp;                                 // Stack access this cycle

  // Decoder side drives every bit
  modport decoder (
    output aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch,
    output outEn, inEn, pushPop, pushPc, popPc, stackOp
  );

  // Consumers only observe
  modport user (
    input aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch,
    input outEn, inEn, pushPop, pushPc, popPc, stackOp
  );

endinterface

// ==== src/controlUnit.sv ====
// Control decoder turning opcode and interrupt into the control bit set
module controlUnit (
  input  logic [cpuPkg::OPC_W-1:0] opcode,       // Gated opcode from sequencer
  input  logic                     interrupt,    // Taken interrupt, overrides opcode
  ctrlIf.decoder                   ctrl,         // Decoded control bits
  output logic                     callStart     // Starts the call bubble
);

  assign ctrl.aluOp = 1'b0;                      // No ALU op select needed here

  // Call or interrupt both enter the bubble sequence
  assign callStart = interrupt | (opcode == cpuPkg::OPC_CALL);

  always_comb begin
    ctrl.aluSrc   = 1'b0;                        // Defaults, NOP
    ctrl.regWrite = 1'b0;
    ctrl.memRead  = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.outEn    = 1'b0;
    ctrl.inEn     = 1'b0;
    ctrl.pushPop  = 1'b0;
    ctrl.pushPc   = 1'b0;
    ctrl.popPc    = 1'b0;
    ctrl.stackOp  = 1'b0;
    if (interrupt) begin                         // Hardware call to the vector
      ctrl.memWrite = 1'b1;
      ctrl.branch   = 1'b1;
      ctrl.pushPop  = 1'b1;
      ctrl.pushPc   = 1'b1;
      ctrl.stackOp  = 1'b1;
    end else begin
      case (opcode)
        cpuPkg::OPC_NOP, cpuPkg::OPC_SETC: begin
          // Flag ops live outside, nothing to steer
        end
        cpuPkg::OPC_ALU: begin
          ctrl.regWrite = 1'b1;                  // Register result
        end
        cpuPkg::OPC_SHIFT: begin
          ctrl.aluSrc   = 1'b1;                  // Shift amount or LDM immediate
          ctrl.regWrite = 1'b1;
        end
        cpuPkg::OPC_OUT: begin
          ctrl.outEn    = 1'b1;
        end
        cpuPkg::OPC_IN: begin
          ctrl.inEn     = 1'b1;
          ctrl.regWrite = 1'b1;                  // Port value to register
        end
        cpuPkg::OPC_PUSH: begin
          ctrl.memWrite = 1'b1;
          ctrl.pushPop  = 1'b1;
          ctrl.stackOp  = 1'b1;
        end
        cpuPkg::OPC_POP: begin
          ctrl.memRead  = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.regWrite = 1'b1;
          ctrl.stackOp  = 1'b1;                  // pushPop low, pop
        end
        cpuPkg::OPC_LDD: begin
          ctrl.memRead  = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end
        cpuPkg::OPC_STD: begin
          ctrl.memWrite = 1'b1;
        end
        cpuPkg::OPC_JMP: begin
          ctrl.branch   = 1'b1;                  // Taken bit comes from outside
        end
        cpuPkg::OPC_CALL: begin
          ctrl.memWrite = 1'b1;                  // Return address to stack
          ctrl.branch   = 1'b1;
          ctrl.pushPop  = 1'b1;
          ctrl.pushPc   = 1'b1;
          ctrl.stackOp  = 1'b1;
        end
        cpuPkg::OPC_RET, cpuPkg::OPC_RETI: begin
          ctrl.memRead  = 1'b1;                  // Return address from stack
          ctrl.popPc    = 1'b1;
          ctrl.stackOp  = 1'b1;
        end
        default: begin
          // Unused codes decode as NOP
        end
      endcase
    end
  end

endmodule

// ==== src/callSequencer.sv ====
// Call sequencer holding pending interrupts and inserting the post-call bubble
module callSequencer (
  input  logic                     clk,
  input  logic                     rstN,         // Sync, active low
  input  logic                     irq,          // Pulse or level request
  input  logic [cpuPkg::OPC_W-1:0] opcode,       // Raw fetched opcode
  input  logic                     callStart,    // CALL or interrupt decoded
  output logic [cpuPkg::OPC_W-1:0] opcodeEff,    // Opcode seen by decoder
  output logic                     interrupt,    // Interrupt taken this cycle
  output logic                     stall         // Bubble cycle
);

  cpuPkg::seqState state;
  logic            irqPending;                   // Request waiting for IDLE

  // Taken only from IDLE, never inside the bubble
  assign interrupt = (state == cpuPkg::IDLE) & irqPending;

  assign stall     = (state == cpuPkg::BUBBLE);
  assign opcodeEff = stall ? cpuPkg::OPC_NOP : opcode; // Squash during bubble

  always_ff @(posedge clk) begin
    if (!rstN) begin
      irqPending <= 1'b0;
    end else begin
      // New request wins over the clear of one being taken
      irqPending <= irq | (irqPending & ~interrupt);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= cpuPkg::IDLE;
    end else begin
      case (state)
        cpuPkg::IDLE: begin
          if (callStart) begin
            state <= cpuPkg::BUBBLE;             // One dead cycle follows
          end
        end
        cpuPkg::BUBBLE: begin
          state <= cpuPkg::IDLE;                 // Always a single cycle
        end
        default: begin
          state <= cpuPkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== src/pcUnit.sv ====
// Program counter with sequential, jump, call, interrupt vector and return loads
module pcUnit (
  input  logic                      clk,
  input  logic                      rstN,        // Sync, active low
  ctrlIf.user                       ctrl,        // Decoded control bits
  input  logic                      interrupt,   // Interrupt taken
  input  logic                      stall,       // Bubble, hold pc
  input  logic                      jumpTaken,   // Condition met for JMP
  input  logic [cpuPkg::ADDR_W-1:0] jumpTarget,  // Jump and call destination
  input  logic [cpuPkg::ADDR_W-1:0] popData,     // Return address from stack
  output logic [cpuPkg::ADDR_W-1:0] pc,
  output logic [cpuPkg::ADDR_W-1:0] retAddr      // Pushed by CALL and interrupt
);

  logic [cpuPkg::ADDR_W-1:0] pcNext;

  assign retAddr = pc + 1'b1;

  // RET over interrupt over jump over fall-through
  always_comb begin
    if (ctrl.popPc) begin
      pcNext = popData;                          // RET and RETI
    end else if (interrupt) begin
      pcNext = cpuPkg::INT_VECTOR;
    end else if (ctrl.branch && (jumpTaken || ctrl.pushPc)) begin
      pcNext = jumpTarget;                       // Taken jump or CALL
    end else begin
      pcNext = retAddr;                          // Next sequential
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pcNext;
    end
  end

endmodule

// ==== src/stackUnit.sv ====
// Stack pointer with push and pop address generation for a downward stack
module stackUnit (
  input  logic                      clk,
  input  logic                      rstN,        // Sync, active low
  ctrlIf.user                       ctrl,        // Decoded control bits
  input  logic                      stall,       // Bubble, hold sp
  output logic [cpuPkg::ADDR_W-1:0] sp,
  output logic [cpuPkg::ADDR_W-1:0] stackAddr    // Data memory address for stack
);

  logic doPush;
  logic doPop;
  logic [cpuPkg::ADDR_W-1:0] spInc;

  assign doPush = ctrl.stackOp & ctrl.pushPop;
  assign doPop  = ctrl.stackOp & ~ctrl.pushPop;
  assign spInc  = sp + 1'b1;

  // sp points at the free slot, a pop reads the one above
  assign stackAddr = doPop ? spInc : sp;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      sp <= cpuPkg::STACK_TOP;
    end else if (!stall) begin
      if (doPush) begin
        sp <= sp - 1'b1;                         // Grows down
      end else if (doPop) begin
        sp <= spInc;
      end
    end
  end

endmodule

// ==== src/decodeStage.sv ====
// Decode stage top joining sequencer, decoder, program counter and stack pointer
module decodeStage (
  input  logic                      clk,
  input  logic                      rstN,        // Sync, active low
  input  logic [cpuPkg::OPC_W-1:0]  opcode,      // Fetched opcode
  input  logic                      irq,         // Interrupt request
  input  logic                      jumpTaken,   // Jump condition result
  input  logic [cpuPkg::ADDR_W-1:0] jumpTarget,
  input  logic [cpuPkg::ADDR_W-1:0] popData,     // Word read at stackAddr
  output logic                      aluOp,
  output logic                      aluSrc,
  output logic                      regWrite,
  output logic                      memRead,
  output logic                      memWrite,
  output logic                      memToReg,
  output logic                      branch,
  output logic                      outEn,
  output logic                      inEn,
  output logic                      pushPop,
  output logic                      pushPc,
  output logic                      popPc,
  output logic                      stackOp,
  output logic [cpuPkg::ADDR_W-1:0] pc,
  output logic [cpuPkg::ADDR_W-1:0] retAddr,
  output logic [cpuPkg::ADDR_W-1:0] sp,
  output logic [cpuPkg::ADDR_W-1:0] stackAddr,
  output logic                      stall        // Bubble after call
);

  logic [cpuPkg::OPC_W-1:0] opcodeEff;           // NOP during bubble
  logic                     interrupt;
  logic                     callStart;

  ctrlIf ctrlBus ();

  callSequencer i_callSequencer (
    .clk       (clk),
    .rstN      (rstN),
    .irq       (irq),
    .opcode    (opcode),
    .callStart (callStart),
    .opcodeEff (opcodeEff),
    .interrupt (interrupt),
    .stall     (stall)
  );

  controlUnit i_controlUnit (
    .opcode    (opcodeEff),
    .interrupt (interrupt),
    .ctrl      (ctrlBus.decoder),
    .callStart (callStart)
  );

  pcUnit i_pcUnit (
    .clk        (clk),
    .rstN       (rstN),
    .ctrl       (ctrlBus.user),
    .interrupt  (interrupt),
    .stall      (stall),
    .jumpTaken  (jumpTaken),
    .jumpTarget (jumpTarget),
    .popData    (popData),
    .pc         (pc),
    .retAddr    (retAddr)
  );

  stackUnit i_stackUnit (
    .clk       (clk),
    .rstN      (rstN),
    .ctrl      (ctrlBus.user),
    .stall     (stall),
    .sp        (sp),
    .stackAddr (stackAddr)
  );

  // Control bits out as plain ports
  assign aluOp    = ctrlBus.aluOp;
  assign aluSrc   = ctrlBus.aluSrc;
  assign regWrite = ctrlBus.regWrite;
  assign memRead  = ctrlBus.memRead;
  assign memWrite = ctrlBus.memWrite;
  assign memToReg = ctrlBus.memToReg;
  assign branch   = ctrlBus.branch;
  assign outEn    = ctrlBus.outEn;
  assign inEn     = ctrlBus.inEn;
  assign pushPop  = ctrlBus.pushPop;
  assign pushPc   = ctrlBus.pushPc;
  assign popPc    = ctrlBus.popPc;
  assign stackOp  = ctrlBus.stackOp;

endmodule

// ==== sim/decodeStage_chk.sv ====
// Decode stage checker asserting memory exclusivity and single quiet bubble cycles
module decodeStage_chk (
  input logic        clk,
  input logic        rstN,
  input logic        memRead,
  input logic        memWrite,
  input logic        stall,
  input logic [12:0] ctrlBits                    // All control outputs
);

  memExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memRead && memWrite))
    else $error("memRead and memWrite high in the same cycle");

  bubbleQuiet: assert property (@(posedge clk) disable iff (!rstN)
    stall |-> (ctrlBits == '0))
    else $error("control bit high during stall");

  // Bubble lasts exactly one cycle
  bubbleSingle: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> !stall)
    else $error("stall high on two cycles in a row");

endmodule

bind decodeStage decodeStage_chk i_decodeStage_chk (
  .clk      (clk),
  .rstN     (rstN),
  .memRead  (memRead),
  .memWrite (memWrite),
  .stall    (stall),
  .ctrlBits ({aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch,
              outEn, inEn, pushPop, pushPc, popPc, stackOp})
);

// ==== sim/decodeStage_tb.sv ====
// Decode stage testbench running directed tests on decode, fetch, calls, stack and interrupts
module decodeStage_tb;

  logic                      clk;
  logic                      rstN;
  logic [cpuPkg::OPC_W-1:0]  opcode;
  logic                      irq;
  logic                      jumpTaken;
  logic [cpuPkg::ADDR_W-1:0] jumpTarget;
  logic [cpuPkg::ADDR_W-1:0] popData;
  logic                      aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch;
  logic                      outEn, inEn, pushPop, pushPc, popPc, stackOp, stall;
  logic [cpuPkg::ADDR_W-1:0] pc, retAddr, sp, stackAddr;
  logic [12:0]               ctrlBits;           // All control outputs, aluOp first

  int errors;
  int errorsBefore;                              // Mismatch count at test start
  int testsRun;
  int testsFailed;

  localparam logic [cpuPkg::OPC_W-1:0] opList [14] = '{
    cpuPkg::OPC_NOP, cpuPkg::OPC_SETC, cpuPkg::OPC_ALU, cpuPkg::OPC_OUT, cpuPkg::OPC_IN,
    cpuPkg::OPC_SHIFT, cpuPkg::OPC_PUSH, cpuPkg::OPC_POP, cpuPkg::OPC_JMP, cpuPkg::OPC_CALL,
    cpuPkg::OPC_RET, cpuPkg::OPC_LDD, cpuPkg::OPC_STD, cpuPkg::OPC_RETI
  };

  assign ctrlBits = {aluOp, aluSrc, regWrite, memRead, memWrite, memToReg, branch,
                     outEn, inEn, pushPop, pushPc, popPc, stackOp};

  decodeStage i_decodeStage (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                      // Period 40
  end

  // Reference decode table, same bit order as ctrlBits
  function automatic logic [12:0] ctrlTable(input logic [cpuPkg::OPC_W-1:0] op);
    case (op)
      cpuPkg::OPC_ALU:   return 13'b0_0100_0000_0000;  // regWrite
      cpuPkg::OPC_SHIFT: return 13'b0_1100_0000_0000;  // aluSrc regWrite
      cpuPkg::OPC_OUT:   return 13'b0_0000_0010_0000;  // outEn
      cpuPkg::OPC_IN:    return 13'b0_0100_0001_0000;  // inEn regWrite
      cpuPkg::OPC_PUSH:  return 13'b0_0001_0000_1001;  // memWrite pushPop stackOp
      cpuPkg::OPC_POP:   return 13'b0_0110_1000_0001;  // Read into register, pop
      cpuPkg::OPC_LDD:   return 13'b0_0110_1000_0000;
      cpuPkg::OPC_STD:   return 13'b0_0001_0000_0000;
      cpuPkg::OPC_JMP:   return 13'b0_0000_0100_0000;  // branch
      cpuPkg::OPC_CALL:  return 13'b0_0001_0100_1101;  // Push pc and branch
      cpuPkg::OPC_RET, cpuPkg::OPC_RETI: return 13'b0_0010_0000_0011;
      default:           return 13'b0;               // NOP and SETC
    endcase
  endfunction

  task automatic flagMismatch(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    $display("[FAIL] %s got %h expected %h", name, got, exp);
    errors++;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errors != errorsBefore) testsFailed++;
    $display("%s: %0d mismatches", name, errors - errorsBefore);
    errorsBefore = errors;
  endtask

  // Inputs change on the falling edge, outputs are read a quarter period later
  task automatic driveCycle(input logic [cpuPkg::OPC_W-1:0] op, input logic taken = 1'b0,
                            input logic req = 1'b0, input logic [15:0] tgt = '0,
                            input logic [15:0] pd = '0);
    @(negedge clk);
    opcode     = op;
    jumpTaken  = taken;
    irq        = req;
    jumpTarget = tgt;
    popData    = pd;
    #10;
  endtask

  task automatic applyReset();
    @(negedge clk);
    rstN   = 1'b0;
    opcode = cpuPkg::OPC_NOP;
    irq    = 1'b0;
    repeat (5) @(negedge clk);                   // Five rising edges in reset
    rstN = 1'b1;
    #10;
  endtask

  // Steps NOP cycles until the bubble is gone
  task automatic waitIdle();
    int n;
    n = 0;
    do begin
      driveCycle(cpuPkg::OPC_NOP);
      n++;
    end while (stall && n < 8);
    if (stall) begin
      $display("Timeout: stall still high after 8 cycles");
      errors++;
    end
  endtask

  task automatic resetAndDecode();
    if (pc !== '0) flagMismatch("pc", pc, '0);
    if (sp !== cpuPkg::STACK_TOP) flagMismatch("sp", sp, cpuPkg::STACK_TOP);
    if (stall !== 1'b0) flagMismatch("stall", 16'(stall), '0);
    foreach (opList[i]) begin
      driveCycle(opList[i]);
      if (ctrlBits !== ctrlTable(opList[i])) begin
        flagMismatch($sformatf("ctrl for opcode %h", opList[i]), 16'(ctrlBits),
                     16'(ctrlTable(opList[i])));
      end
      waitIdle();                                // CALL leaves a bubble behind
    end
    finishTest("reset and decode");
  endtask

  task automatic fetchAndJump();
    logic [cpuPkg::ADDR_W-1:0] tgt;
    tgt = 16'($urandom);
    applyReset();
    driveCycle(cpuPkg::OPC_NOP);
    if (pc !== 16'd1) flagMismatch("pc", pc, 16'd1);
    driveCycle(cpuPkg::OPC_JMP, 1'b0, 1'b0, tgt);  // Condition false
    if (pc !== 16'd2) flagMismatch("pc", pc, 16'd2);
    driveCycle(cpuPkg::OPC_JMP, 1'b1, 1'b0, tgt);  // Condition true
    if (pc !== 16'd3) flagMismatch("pc", pc, 16'd3);
    driveCycle(cpuPkg::OPC_NOP);
    if (pc !== tgt) flagMismatch("pc", pc, tgt);
    finishTest("fetch and jump");
  endtask

  task automatic callAndReturn();
    logic [cpuPkg::ADDR_W-1:0] tgt;
    logic [cpuPkg::ADDR_W-1:0] pd;
    tgt = 16'($urandom);
    pd  = 16'($urandom);
    applyReset();
    driveCycle(cpuPkg::OPC_CALL, 1'b0, 1'b0, tgt);  // At pc 1
    if (stackAddr !== cpuPkg::STACK_TOP)
      flagMismatch("stackAddr", stackAddr, cpuPkg::STACK_TOP);
    if (memWrite !== 1'b1) flagMismatch("memWrite", 16'(memWrite), 16'h1);
    if (retAddr !== 16'd2) flagMismatch("retAddr", retAddr, 16'd2);
    driveCycle(cpuPkg::OPC_NOP);
    if (stall !== 1'b1) flagMismatch("stall", 16'(stall), 16'h1);
    if (ctrlBits !== '0) flagMismatch("ctrl in bubble", 16'(ctrlBits), '0);
    driveCycle(cpuPkg::OPC_NOP);
    if (stall !== 1'b0) flagMismatch("stall", 16'(stall), '0);
    if (pc !== tgt) flagMismatch("pc", pc, tgt);
    if (sp !== cpuPkg::STACK_TOP - 16'd1) flagMismatch("sp", sp, cpuPkg::STACK_TOP - 16'd1);
    driveCycle(cpuPkg::OPC_RET, 1'b0, 1'b0, '0, pd);
    driveCycle(cpuPkg::OPC_NOP);
    if (pc !== pd) flagMismatch("pc", pc, pd);
    if (sp !== cpuPkg::STACK_TOP) flagMismatch("sp", sp, cpuPkg::STACK_TOP);
    finishTest("call and return");
  endtask

  task automatic pushThenPop();
    applyReset();
    driveCycle(cpuPkg::OPC_PUSH);
    if (stackAddr !== cpuPkg::STACK_TOP)
      flagMismatch("stackAddr", stackAddr, cpuPkg::STACK_TOP);
    driveCycle(cpuPkg::OPC_POP);
    if (sp !== cpuPkg::STACK_TOP - 16'd1) flagMismatch("sp", sp, cpuPkg::STACK_TOP - 16'd1);
    if (stackAddr !== cpuPkg::STACK_TOP)         // Slot above sp
      flagMismatch("stackAddr", stackAddr, cpuPkg::STACK_TOP);
    driveCycle(cpuPkg::OPC_NOP);
    if (sp !== cpuPkg::STACK_TOP) flagMismatch("sp", sp, cpuPkg::STACK_TOP);
    finishTest("push then pop");
  endtask

  task automatic interruptEntry();
    applyReset();
    driveCycle(cpuPkg::OPC_NOP, 1'b0, 1'b1);     // One-cycle irq pulse
    driveCycle(cpuPkg::OPC_NOP);                 // Taken here, at pc 2
    if (ctrlBits !== ctrlTable(cpuPkg::OPC_CALL))
      flagMismatch("ctrl on interrupt", 16'(ctrlBits), 16'(ctrlTable(cpuPkg::OPC_CALL)));
    if (retAddr !== 16'd3) flagMismatch("retAddr", retAddr, 16'd3);
    driveCycle(cpuPkg::OPC_NOP, 1'b0, 1'b1);     // Second request inside the bubble
    if (stall !== 1'b1) flagMismatch("stall", 16'(stall), 16'h1);
    if (pc !== cpuPkg::INT_VECTOR) flagMismatch("pc", pc, cpuPkg::INT_VECTOR);
    driveCycle(cpuPkg::OPC_NOP);
    if (stall !== 1'b0) flagMismatch("stall", 16'(stall), '0);
    if (ctrlBits !== ctrlTable(cpuPkg::OPC_CALL))
      flagMismatch("ctrl on interrupt", 16'(ctrlBits), 16'(ctrlTable(cpuPkg::OPC_CALL)));
    if (sp !== cpuPkg::STACK_TOP - 16'd1) flagMismatch("sp", sp, cpuPkg::STACK_TOP - 16'd1);
    waitIdle();
    if (pc !== cpuPkg::INT_VECTOR) flagMismatch("pc", pc, cpuPkg::INT_VECTOR);  // Vector again
    finishTest("interrupt entry");
  endtask

  initial begin
    rstN         = 1'b0;
    opcode       = cpuPkg::OPC_NOP;
    irq          = 1'b0;
    jumpTaken    = 1'b0;
    jumpTarget   = '0;
    popData      = '0;
    errors       = 0;
    errorsBefore = 0;
    testsRun     = 0;
    testsFailed  = 0;
    void'($urandom(5978));
    applyReset();
    resetAndDecode();
    fetchAndJump();
    callAndReturn();
    pushThenPop();
    interruptEntry();
    $display("Summary: %0d tests, %0d failed, %0d mismatches", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/cpuPkg.sv
src/ctrlIf.sv
src/controlUnit.sv
src/callSequencer.sv
src/pcUnit.sv
src/stackUnit.sv
src/decodeStage.sv
sim/decodeStage_chk.sv
sim/decodeStage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation output
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f all.f --top-module decodeStage_tb -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -qx "No errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
